// File: common/io_route_config.svh
// Fixed pin map of the board wrapper pad routing.
// Include this wherever a pin index or pad count is needed.

`ifndef IO_ROUTE_CONFIG_SVH
`define IO_ROUTE_CONFIG_SVH

// Pad counts
`define IO_NUM_MIO 32
`define IO_NUM_DIO 15

//////////////////////////////
// DIO pin indices
//////////////////////////////

// USB device pins
`define IO_DIO_USB_DN        0
`define IO_DIO_USB_DP        1
`define IO_DIO_USB_D         2
`define IO_DIO_USB_DN_PULLUP 5
`define IO_DIO_USB_DP_PULLUP 6
`define IO_DIO_USB_SENSE     8

// SPI device pins, shared with JTAG when the strap is set
`define IO_DIO_SPI_SDO 11
`define IO_DIO_SPI_SDI 12
`define IO_DIO_SPI_CSB 13
`define IO_DIO_SPI_SCK 14

//////////////////////////////
// MIO strap indices
//////////////////////////////

// Debug port enable, high selects JTAG
`define IO_MIO_JTAG_EN   16
// JTAG resets, both active low
`define IO_MIO_JTAG_TRST 18
`define IO_MIO_JTAG_SRST 19
// Board switch selecting the external USB PHY
`define IO_MIO_UPHY_SEL  2

`endif

// File: common/io_route_pkg.sv
// Pin vector types shared by the pad routing RTL and its testbench.
// Widths come from the board pin map header.

`include "io_route_config.svh"

package io_route_pkg;

  //////////////////////////////
  // Pin vectors
  //////////////////////////////

  // One bit per muxed pin, indexed by MIO number
  typedef logic [`IO_NUM_MIO-1:0] mio_vec_t;

  // One bit per dedicated pin, indexed by DIO number
  typedef logic [`IO_NUM_DIO-1:0] dio_vec_t;

endpackage

// File: jtag_overlay/jtag_overlay_mux.sv
// JTAG overlay between the core pin vectors and the pads.
// The strap on MIO 16 hands the SPI device pins and two MIOs to the debug port.

`timescale 1ns/1ps
`include "io_route_config.svh"

module jtag_overlay_mux (
  // Core side, MIO direct and DIO from the pin-flip mux
  input  io_route_pkg::mio_vec_t mio_out_core_i,
  input  io_route_pkg::mio_vec_t mio_oe_core_i,
  output io_route_pkg::mio_vec_t mio_in_core_o,
  input  io_route_pkg::dio_vec_t dio_out_umux_i,
  input  io_route_pkg::dio_vec_t dio_oe_umux_i,
  output io_route_pkg::dio_vec_t dio_in_umux_o,
  // Pad side
  input  io_route_pkg::mio_vec_t mio_in_pad_i,
  input  io_route_pkg::dio_vec_t dio_in_pad_i,
  output io_route_pkg::mio_vec_t mio_out_pad_o,
  output io_route_pkg::mio_vec_t mio_oe_pad_o,
  output io_route_pkg::dio_vec_t dio_out_pad_o,
  output io_route_pkg::dio_vec_t dio_oe_pad_o,
  // Debug port
  output logic                   jtag_tck_o,
  output logic                   jtag_tms_o,
  output logic                   jtag_tdi_o,
  output logic                   jtag_trst_n_o,
  output logic                   jtag_srst_n_o,
  input  logic                   jtag_tdo_i
);

  import io_route_pkg::*;

  // MIOs taken by the debug port (TRST and SRST)
  localparam mio_vec_t MIO_JTAG_MASK =
      (mio_vec_t'(1) << `IO_MIO_JTAG_TRST) |
      (mio_vec_t'(1) << `IO_MIO_JTAG_SRST);

  // DIOs taken by the debug port
  localparam dio_vec_t DIO_JTAG_MASK =
      (dio_vec_t'(1) << `IO_DIO_SPI_SCK) |
      (dio_vec_t'(1) << `IO_DIO_SPI_CSB) |
      (dio_vec_t'(1) << `IO_DIO_SPI_SDI) |
      (dio_vec_t'(1) << `IO_DIO_SPI_SDO);

  // Value the core sees on taken DIOs; CSB idles high
  localparam dio_vec_t DIO_TIE_OFF = dio_vec_t'(1) << `IO_DIO_SPI_CSB;

  logic jtag_en;

  //////////////////////////////
  // Strap decode
  //////////////////////////////

  assign jtag_en = mio_in_pad_i[`IO_MIO_JTAG_EN];

  //////////////////////////////
  // Pin routing
  //////////////////////////////

  always_comb begin
    // Straight through unless the debug port owns the pins
    mio_in_core_o = mio_in_pad_i;
    dio_in_umux_o = dio_in_pad_i;
    mio_out_pad_o = mio_out_core_i;
    mio_oe_pad_o  = mio_oe_core_i;
    dio_out_pad_o = dio_out_umux_i;
    dio_oe_pad_o  = dio_oe_umux_i;

    if (jtag_en) begin
      // Core sees tie-offs on the taken pins
      mio_in_core_o = mio_in_pad_i & ~MIO_JTAG_MASK;
      dio_in_umux_o = (dio_in_pad_i & ~DIO_JTAG_MASK) | DIO_TIE_OFF;

      // Core can no longer drive the taken pins
      mio_out_pad_o = mio_out_core_i & ~MIO_JTAG_MASK;
      mio_oe_pad_o  = mio_oe_core_i & ~MIO_JTAG_MASK;
      dio_out_pad_o = dio_out_umux_i & ~DIO_JTAG_MASK;
      dio_oe_pad_o  = dio_oe_umux_i & ~DIO_JTAG_MASK;

      // TDO is the only debug pin driven towards the board
      dio_out_pad_o[`IO_DIO_SPI_SDO] = jtag_tdo_i;
      dio_oe_pad_o[`IO_DIO_SPI_SDO]  = 1'b1;
    end
  end

  //////////////////////////////
  // Debug port
  //////////////////////////////

  always_comb begin
    // Idle port, resets released
    jtag_tck_o    = 1'b0;
    jtag_tms_o    = 1'b0;
    jtag_tdi_o    = 1'b0;
    jtag_trst_n_o = 1'b1;
    jtag_srst_n_o = 1'b1;

    if (jtag_en) begin
      jtag_tck_o    = dio_in_pad_i[`IO_DIO_SPI_SCK];
      jtag_tms_o    = dio_in_pad_i[`IO_DIO_SPI_CSB];
      jtag_tdi_o    = dio_in_pad_i[`IO_DIO_SPI_SDI];
      jtag_trst_n_o = mio_in_pad_i[`IO_MIO_JTAG_TRST];
      jtag_srst_n_o = mio_in_pad_i[`IO_MIO_JTAG_SRST];
    end
  end

endmodule

// File: usb_pinflip/usb_pinflip_mux.sv
// USB pin-flip undo and external PHY selection on the DIO vector.
// The board always sees D+ and D- unflipped, whatever the core has set.

`timescale 1ns/1ps
`include "io_route_config.svh"

module usb_pinflip_mux (
  // Core side
  input  io_route_pkg::dio_vec_t dio_out_core_i,
  input  io_route_pkg::dio_vec_t dio_oe_core_i,
  output io_route_pkg::dio_vec_t dio_in_core_o,
  // Towards the JTAG overlay mux
  output io_route_pkg::dio_vec_t dio_out_umux_o,
  output io_route_pkg::dio_vec_t dio_oe_umux_o,
  input  io_route_pkg::dio_vec_t dio_in_umux_i,
  // External USB PHY
  input  logic                   use_uphy_i,
  input  logic                   uphy_dp_rx_i,
  input  logic                   uphy_dn_rx_i,
  input  logic                   uphy_d_rx_i,
  input  logic                   uphy_sense_i,
  output logic                   uphy_dp_tx_o,
  output logic                   uphy_dn_tx_o,
  output logic                   uphy_dppullup_o,
  output logic                   uphy_oe_n_o
);

  import io_route_pkg::*;

  logic     undo_swap;
  logic     rx_dn;
  logic     rx_dp;
  logic     rx_d;
  dio_vec_t dio_out_umux;
  dio_vec_t dio_oe_umux;

  // The core enables the DN pullup only when its pins are flipped
  assign undo_swap = dio_oe_core_i[`IO_DIO_USB_DN_PULLUP];

  //////////////////////////////
  // Transmit path
  //////////////////////////////

  always_comb begin
    dio_out_umux = dio_out_core_i;
    dio_oe_umux  = dio_oe_core_i;

    if (undo_swap) begin
      // Data lines
      dio_out_umux[`IO_DIO_USB_DN] = dio_out_core_i[`IO_DIO_USB_DP];
      dio_out_umux[`IO_DIO_USB_DP] = dio_out_core_i[`IO_DIO_USB_DN];
      dio_oe_umux[`IO_DIO_USB_DN]  = dio_oe_core_i[`IO_DIO_USB_DP];
      dio_oe_umux[`IO_DIO_USB_DP]  = dio_oe_core_i[`IO_DIO_USB_DN];

      // Pullups follow the data lines
      dio_out_umux[`IO_DIO_USB_DN_PULLUP] = dio_out_core_i[`IO_DIO_USB_DP_PULLUP];
      dio_out_umux[`IO_DIO_USB_DP_PULLUP] = dio_out_core_i[`IO_DIO_USB_DN_PULLUP];
      dio_oe_umux[`IO_DIO_USB_DN_PULLUP]  = dio_oe_core_i[`IO_DIO_USB_DP_PULLUP];
      dio_oe_umux[`IO_DIO_USB_DP_PULLUP]  = dio_oe_core_i[`IO_DIO_USB_DN_PULLUP];

      // Differential data flips polarity, its enable stays put
      dio_out_umux[`IO_DIO_USB_D] = ~dio_out_core_i[`IO_DIO_USB_D];
    end
  end

  assign dio_out_umux_o = dio_out_umux;
  assign dio_oe_umux_o  = dio_oe_umux;

  //////////////////////////////
  // Receive path
  //////////////////////////////

  // Pads or external PHY, before the swap is undone
  assign rx_dn = use_uphy_i ? uphy_dn_rx_i : dio_in_umux_i[`IO_DIO_USB_DN];
  assign rx_dp = use_uphy_i ? uphy_dp_rx_i : dio_in_umux_i[`IO_DIO_USB_DP];
  assign rx_d  = use_uphy_i ? uphy_d_rx_i  : dio_in_umux_i[`IO_DIO_USB_D];

  always_comb begin
    dio_in_core_o = dio_in_umux_i;

    dio_in_core_o[`IO_DIO_USB_DN] = undo_swap ? rx_dp : rx_dn;
    dio_in_core_o[`IO_DIO_USB_DP] = undo_swap ? rx_dn : rx_dp;
    dio_in_core_o[`IO_DIO_USB_D]  = undo_swap ? ~rx_d : rx_d;

    // VBUS sense from the PHY board
    if (use_uphy_i) begin
      dio_in_core_o[`IO_DIO_USB_SENSE] = uphy_sense_i;
    end
  end

  //////////////////////////////
  // External PHY outputs
  //////////////////////////////

  // Copies of the unflipped pad drive, always active
  assign uphy_dp_tx_o = dio_out_umux[`IO_DIO_USB_DP];
  assign uphy_dn_tx_o = dio_out_umux[`IO_DIO_USB_DN];

  // Pullup only when driven high and enabled
  assign uphy_dppullup_o = dio_out_umux[`IO_DIO_USB_DP_PULLUP] &
                           dio_oe_umux[`IO_DIO_USB_DP_PULLUP];

  // PHY transmit enable is active low
  assign uphy_oe_n_o = ~dio_oe_umux[`IO_DIO_USB_DP];

endmodule

// File: logic/reset_sync.sv
// Board reset combined with the JTAG system reset.
// Asserts at once, releases on the second clock edge.

`timescale 1ns/1ps

module reset_sync (
  input  logic io_clk_i,
  input  logic rst_n_i,
  input  logic jtag_srst_n_i,
  output logic rst_n_o
);

  logic       rst_n_comb;
  logic [1:0] sync_q;

  // Either source pulls the reset low
  assign rst_n_comb = rst_n_i & jtag_srst_n_i;

  // Two-flop release synchronizer
  always_ff @(posedge io_clk_i or negedge rst_n_comb) begin
    if (!rst_n_comb) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_n_o = sync_q[1];

endmodule

// File: logic/io_route_top.sv
// Top of the pad routing layer of the board wrapper.
// Chain is core, pin-flip mux, JTAG overlay mux, pads; plus the reset synchronizer.

`timescale 1ns/1ps
`include "io_route_config.svh"

module io_route_top (
  // Clock and reset
  input  logic                   io_clk_i,
  input  logic                   rst_n_i,
  output logic                   rst_n_o,
  // Core side
  input  io_route_pkg::mio_vec_t mio_out_core_i,
  input  io_route_pkg::mio_vec_t mio_oe_core_i,
  output io_route_pkg::mio_vec_t mio_in_core_o,
  input  io_route_pkg::dio_vec_t dio_out_core_i,
  input  io_route_pkg::dio_vec_t dio_oe_core_i,
  output io_route_pkg::dio_vec_t dio_in_core_o,
  // Pad side
  input  io_route_pkg::mio_vec_t mio_in_pad_i,
  input  io_route_pkg::dio_vec_t dio_in_pad_i,
  output io_route_pkg::mio_vec_t mio_out_pad_o,
  output io_route_pkg::mio_vec_t mio_oe_pad_o,
  output io_route_pkg::dio_vec_t dio_out_pad_o,
  output io_route_pkg::dio_vec_t dio_oe_pad_o,
  // Debug port
  output logic                   jtag_tck_o,
  output logic                   jtag_tms_o,
  output logic                   jtag_tdi_o,
  output logic                   jtag_trst_n_o,
  input  logic                   jtag_tdo_i,
  // External USB PHY
  input  logic                   uphy_dp_rx_i,
  input  logic                   uphy_dn_rx_i,
  input  logic                   uphy_d_rx_i,
  input  logic                   uphy_sense_i,
  output logic                   uphy_dp_tx_o,
  output logic                   uphy_dn_tx_o,
  output logic                   uphy_dppullup_o,
  output logic                   uphy_oe_n_o
);

  import io_route_pkg::*;

  // DIO vectors between the pin-flip mux and the overlay mux
  dio_vec_t dio_out_umux;
  dio_vec_t dio_oe_umux;
  dio_vec_t dio_in_umux;

  logic jtag_srst_n;
  logic use_uphy;

  // Board switch picks the external PHY
  assign use_uphy = mio_in_pad_i[`IO_MIO_UPHY_SEL];

  //////////////////////////////
  // USB pin-flip mux
  //////////////////////////////

  usb_pinflip_mux i_usb_pinflip_mux (
    .dio_out_core_i  ( dio_out_core_i  ),
    .dio_oe_core_i   ( dio_oe_core_i   ),
    .dio_in_core_o   ( dio_in_core_o   ),
    .dio_out_umux_o  ( dio_out_umux    ),
    .dio_oe_umux_o   ( dio_oe_umux     ),
    .dio_in_umux_i   ( dio_in_umux     ),
    .use_uphy_i      ( use_uphy        ),
    .uphy_dp_rx_i    ( uphy_dp_rx_i    ),
    .uphy_dn_rx_i    ( uphy_dn_rx_i    ),
    .uphy_d_rx_i     ( uphy_d_rx_i     ),
    .uphy_sense_i    ( uphy_sense_i    ),
    .uphy_dp_tx_o    ( uphy_dp_tx_o    ),
    .uphy_dn_tx_o    ( uphy_dn_tx_o    ),
    .uphy_dppullup_o ( uphy_dppullup_o ),
    .uphy_oe_n_o     ( uphy_oe_n_o     )
  );

  //////////////////////////////
  // JTAG overlay mux
  //////////////////////////////

  jtag_overlay_mux i_jtag_overlay_mux (
    .mio_out_core_i ( mio_out_core_i ),
    .mio_oe_core_i  ( mio_oe_core_i  ),
    .mio_in_core_o  ( mio_in_core_o  ),
    .dio_out_umux_i ( dio_out_umux   ),
    .dio_oe_umux_i  ( dio_oe_umux    ),
    .dio_in_umux_o  ( dio_in_umux    ),
    .mio_in_pad_i   ( mio_in_pad_i   ),
    .dio_in_pad_i   ( dio_in_pad_i   ),
    .mio_out_pad_o  ( mio_out_pad_o  ),
    .mio_oe_pad_o   ( mio_oe_pad_o   ),
    .dio_out_pad_o  ( dio_out_pad_o  ),
    .dio_oe_pad_o   ( dio_oe_pad_o   ),
    .jtag_tck_o     ( jtag_tck_o     ),
    .jtag_tms_o     ( jtag_tms_o     ),
    .jtag_tdi_o     ( jtag_tdi_o     ),
    .jtag_trst_n_o  ( jtag_trst_n_o  ),
    .jtag_srst_n_o  ( jtag_srst_n    ),
    .jtag_tdo_i     ( jtag_tdo_i     )
  );

  // System reset for the core
  reset_sync i_reset_sync (
    .io_clk_i      ( io_clk_i    ),
    .rst_n_i       ( rst_n_i     ),
    .jtag_srst_n_i ( jtag_srst_n ),
    .rst_n_o       ( rst_n_o     )
  );

endmodule

// File: sim/tb_io_route.sv
// Directed testbench for the pad routing layer.
// Drives the core, pad, debug and USB PHY inputs and checks every output against a pin-map model.

`timescale 1ns/1ps
`include "io_route_config.svh"

module tb_io_route;

  import io_route_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 8;
  localparam int RELEASE_TIMEOUT = 10;
  localparam int VECTORS         = 8;

  logic     io_clk_i;
  logic     rst_n_i;
  logic     rst_n_o;
  mio_vec_t mio_out_core_i, mio_oe_core_i, mio_in_core_o;
  dio_vec_t dio_out_core_i, dio_oe_core_i, dio_in_core_o;
  mio_vec_t mio_in_pad_i, mio_out_pad_o, mio_oe_pad_o;
  dio_vec_t dio_in_pad_i, dio_out_pad_o, dio_oe_pad_o;
  logic     jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o, jtag_tdo_i;
  logic     uphy_dp_rx_i, uphy_dn_rx_i, uphy_d_rx_i, uphy_sense_i;
  logic     uphy_dp_tx_o, uphy_dn_tx_o, uphy_dppullup_o, uphy_oe_n_o;

  // Expected responses
  mio_vec_t exp_mio_in, exp_mio_out, exp_mio_oe;
  dio_vec_t exp_dio_in, exp_dio_out, exp_dio_oe;
  logic [3:0] exp_jtag;
  logic [3:0] exp_phy;

  integer seed = 32'h4174;
  int     error_count  = 0;
  int     test_errors  = 0;
  int     tests_run    = 0;
  int     tests_failed = 0;

  io_route_top i_io_route_top (
    .io_clk_i        ( io_clk_i        ),
    .rst_n_i         ( rst_n_i         ),
    .rst_n_o         ( rst_n_o         ),
    .mio_out_core_i  ( mio_out_core_i  ),
    .mio_oe_core_i   ( mio_oe_core_i   ),
    .mio_in_core_o   ( mio_in_core_o   ),
    .dio_out_core_i  ( dio_out_core_i  ),
    .dio_oe_core_i   ( dio_oe_core_i   ),
    .dio_in_core_o   ( dio_in_core_o   ),
    .mio_in_pad_i    ( mio_in_pad_i    ),
    .dio_in_pad_i    ( dio_in_pad_i    ),
    .mio_out_pad_o   ( mio_out_pad_o   ),
    .mio_oe_pad_o    ( mio_oe_pad_o    ),
    .dio_out_pad_o   ( dio_out_pad_o   ),
    .dio_oe_pad_o    ( dio_oe_pad_o    ),
    .jtag_tck_o      ( jtag_tck_o      ),
    .jtag_tms_o      ( jtag_tms_o      ),
    .jtag_tdi_o      ( jtag_tdi_o      ),
    .jtag_trst_n_o   ( jtag_trst_n_o   ),
    .jtag_tdo_i      ( jtag_tdo_i      ),
    .uphy_dp_rx_i    ( uphy_dp_rx_i    ),
    .uphy_dn_rx_i    ( uphy_dn_rx_i    ),
    .uphy_d_rx_i     ( uphy_d_rx_i     ),
    .uphy_sense_i    ( uphy_sense_i    ),
    .uphy_dp_tx_o    ( uphy_dp_tx_o    ),
    .uphy_dn_tx_o    ( uphy_dn_tx_o    ),
    .uphy_dppullup_o ( uphy_dppullup_o ),
    .uphy_oe_n_o     ( uphy_oe_n_o     )
  );

  initial begin
    io_clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) io_clk_i = ~io_clk_i;
  end

  //////////////////////////////
  // Check helpers
  //////////////////////////////

  task automatic check_value(input string test, input string sig,
                             input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected 0x%08h actual 0x%08h", test, sig, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic finish_test(input string test);
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: done, no errors", test);
    end else begin
      tests_failed++;
      $display("%s: done, %0d errors", test, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic randomize_inputs;
    mio_out_core_i = mio_vec_t'($random(seed));
    mio_oe_core_i  = mio_vec_t'($random(seed));
    dio_out_core_i = dio_vec_t'($random(seed));
    dio_oe_core_i  = dio_vec_t'($random(seed));
    mio_in_pad_i   = mio_vec_t'($random(seed));
    dio_in_pad_i   = dio_vec_t'($random(seed));
    {jtag_tdo_i, uphy_dp_rx_i, uphy_dn_rx_i, uphy_d_rx_i, uphy_sense_i} = 5'($random(seed));
  endtask

  //////////////////////////////
  // Pin map model
  //////////////////////////////

  task automatic compute_expected;
    logic     jtag_en;
    logic     use_uphy;
    logic     undo_swap;
    logic     rx_dn;
    logic     rx_dp;
    logic     rx_d;
    dio_vec_t flip_out;
    dio_vec_t flip_oe;
    dio_vec_t flip_in;

    jtag_en   = mio_in_pad_i[`IO_MIO_JTAG_EN];
    use_uphy  = mio_in_pad_i[`IO_MIO_UPHY_SEL];
    undo_swap = dio_oe_core_i[`IO_DIO_USB_DN_PULLUP];

    // Core drive with the USB swap undone
    flip_out = dio_out_core_i;
    flip_oe  = dio_oe_core_i;
    if (undo_swap) begin
      flip_out[`IO_DIO_USB_DN]        = dio_out_core_i[`IO_DIO_USB_DP];
      flip_out[`IO_DIO_USB_DP]        = dio_out_core_i[`IO_DIO_USB_DN];
      flip_oe[`IO_DIO_USB_DN]         = dio_oe_core_i[`IO_DIO_USB_DP];
      flip_oe[`IO_DIO_USB_DP]         = dio_oe_core_i[`IO_DIO_USB_DN];
      flip_out[`IO_DIO_USB_DN_PULLUP] = dio_out_core_i[`IO_DIO_USB_DP_PULLUP];
      flip_out[`IO_DIO_USB_DP_PULLUP] = dio_out_core_i[`IO_DIO_USB_DN_PULLUP];
      flip_oe[`IO_DIO_USB_DN_PULLUP]  = dio_oe_core_i[`IO_DIO_USB_DP_PULLUP];
      flip_oe[`IO_DIO_USB_DP_PULLUP]  = dio_oe_core_i[`IO_DIO_USB_DN_PULLUP];
      flip_out[`IO_DIO_USB_D]         = ~dio_out_core_i[`IO_DIO_USB_D];
    end

    exp_mio_out = mio_out_core_i;
    exp_mio_oe  = mio_oe_core_i;
    exp_mio_in  = mio_in_pad_i;
    exp_dio_out = flip_out;
    exp_dio_oe  = flip_oe;
    flip_in     = dio_in_pad_i;
    exp_jtag    = 4'b0001;

    // Debug port owns SCK, CSB, SDI, SDO, TRST and SRST
    if (jtag_en) begin
      exp_jtag = {dio_in_pad_i[`IO_DIO_SPI_SCK], dio_in_pad_i[`IO_DIO_SPI_CSB],
                  dio_in_pad_i[`IO_DIO_SPI_SDI], mio_in_pad_i[`IO_MIO_JTAG_TRST]};
      exp_mio_in[`IO_MIO_JTAG_TRST]  = 1'b0;
      exp_mio_in[`IO_MIO_JTAG_SRST]  = 1'b0;
      exp_mio_out[`IO_MIO_JTAG_TRST] = 1'b0;
      exp_mio_out[`IO_MIO_JTAG_SRST] = 1'b0;
      exp_mio_oe[`IO_MIO_JTAG_TRST]  = 1'b0;
      exp_mio_oe[`IO_MIO_JTAG_SRST]  = 1'b0;
      flip_in[`IO_DIO_SPI_SCK]       = 1'b0;
      flip_in[`IO_DIO_SPI_SDI]       = 1'b0;
      flip_in[`IO_DIO_SPI_SDO]       = 1'b0;
      flip_in[`IO_DIO_SPI_CSB]       = 1'b1;
      exp_dio_out[`IO_DIO_SPI_SCK]   = 1'b0;
      exp_dio_out[`IO_DIO_SPI_CSB]   = 1'b0;
      exp_dio_out[`IO_DIO_SPI_SDI]   = 1'b0;
      exp_dio_oe[`IO_DIO_SPI_SCK]    = 1'b0;
      exp_dio_oe[`IO_DIO_SPI_CSB]    = 1'b0;
      exp_dio_oe[`IO_DIO_SPI_SDI]    = 1'b0;
      exp_dio_out[`IO_DIO_SPI_SDO]   = jtag_tdo_i;
      exp_dio_oe[`IO_DIO_SPI_SDO]    = 1'b1;
    end

    // Receive side from the pads or the external PHY
    rx_dn = use_uphy ? uphy_dn_rx_i : flip_in[`IO_DIO_USB_DN];
    rx_dp = use_uphy ? uphy_dp_rx_i : flip_in[`IO_DIO_USB_DP];
    rx_d  = use_uphy ? uphy_d_rx_i  : flip_in[`IO_DIO_USB_D];
    exp_dio_in = flip_in;
    exp_dio_in[`IO_DIO_USB_DN] = undo_swap ? rx_dp : rx_dn;
    exp_dio_in[`IO_DIO_USB_DP] = undo_swap ? rx_dn : rx_dp;
    exp_dio_in[`IO_DIO_USB_D]  = undo_swap ? ~rx_d : rx_d;
    if (use_uphy) begin
      exp_dio_in[`IO_DIO_USB_SENSE] = uphy_sense_i;
    end

    exp_phy = {flip_out[`IO_DIO_USB_DP], flip_out[`IO_DIO_USB_DN],
               flip_out[`IO_DIO_USB_DP_PULLUP] & flip_oe[`IO_DIO_USB_DP_PULLUP],
               ~flip_oe[`IO_DIO_USB_DP]};
  endtask

  task automatic compare_outputs(input string test);
    compute_expected();
    check_value(test, "mio_in_core", exp_mio_in, mio_in_core_o);
    check_value(test, "mio_out_pad", exp_mio_out, mio_out_pad_o);
    check_value(test, "mio_oe_pad", exp_mio_oe, mio_oe_pad_o);
    check_value(test, "dio_in_core", exp_dio_in, dio_in_core_o);
    check_value(test, "dio_out_pad", exp_dio_out, dio_out_pad_o);
    check_value(test, "dio_oe_pad", exp_dio_oe, dio_oe_pad_o);
    check_value(test, "jtag tck/tms/tdi/trst_n", exp_jtag,
                {jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o});
    check_value(test, "uphy dp/dn/pullup/oe_n", exp_phy,
                {uphy_dp_tx_o, uphy_dn_tx_o, uphy_dppullup_o, uphy_oe_n_o});
    // SRST pad is ignored while the debug port is off
    check_value(test, "rst_n_o", 1, rst_n_o);
  endtask

  // Counts rising edges until rst_n_o goes high
  task automatic count_release_edges(input string test, output int edges);
    int   n;
    logic seen;

    n    = 0;
    seen = 1'b0;
    while (!seen && n < RELEASE_TIMEOUT) begin
      @(posedge io_clk_i);
      n++;
      #1;
      seen = rst_n_o;
    end
    if (!seen) begin
      $display("%s: rst_n_o did not rise within %0d clock edges", test, RELEASE_TIMEOUT);
      error_count++;
      test_errors++;
    end
    edges = n;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  // Mode is 0 pass-through, 1 JTAG, 2 pin-flip, 3 PHY select
  task automatic run_routing_test(input string test, input int mode);
    for (int i = 0; i < VECTORS; i++) begin
      @(negedge io_clk_i);
      randomize_inputs();
      mio_in_pad_i[`IO_MIO_JTAG_EN]       = (mode == 1);
      if (mode == 1) begin
        mio_in_pad_i[`IO_MIO_JTAG_SRST]   = 1'b1;
      end else begin
        mio_in_pad_i[`IO_MIO_UPHY_SEL]    = (mode == 3);
      end
      if (mode == 0) begin
        dio_oe_core_i[`IO_DIO_USB_DN_PULLUP] = 1'b0;
      end else if (mode == 2) begin
        dio_oe_core_i[`IO_DIO_USB_DN_PULLUP] = 1'b1;
      end else if (mode == 3) begin
        dio_oe_core_i[`IO_DIO_USB_DN_PULLUP] = i[0];
      end
      #(CLK_PERIOD / 4);
      compare_outputs(test);
    end
    finish_test(test);
  endtask

  task automatic reset_test;
    int edges;

    @(negedge io_clk_i);
    mio_in_pad_i = '0;
    rst_n_i      = 1'b0;
    #1;
    check_value("reset", "rst_n_o in board reset", 0, rst_n_o);
    repeat (3) @(negedge io_clk_i);
    check_value("reset", "rst_n_o held in reset", 0, rst_n_o);
    rst_n_i = 1'b1;
    count_release_edges("reset", edges);
    check_value("reset", "edges to board reset release", 2, edges);

    // System reset from the debug port
    @(negedge io_clk_i);
    mio_in_pad_i[`IO_MIO_JTAG_EN]   = 1'b1;
    mio_in_pad_i[`IO_MIO_JTAG_SRST] = 1'b0;
    #1;
    check_value("reset", "rst_n_o on srst", 0, rst_n_o);
    repeat (2) @(negedge io_clk_i);
    mio_in_pad_i[`IO_MIO_JTAG_SRST] = 1'b1;
    count_release_edges("reset", edges);
    check_value("reset", "edges to srst release", 2, edges);
    @(negedge io_clk_i);
    mio_in_pad_i = '0;
    finish_test("reset");
  endtask

  initial begin
    int edges;

    rst_n_i        = 1'b0;
    mio_out_core_i = '0;
    mio_oe_core_i  = '0;
    dio_out_core_i = '0;
    dio_oe_core_i  = '0;
    mio_in_pad_i   = '0;
    dio_in_pad_i   = '0;
    jtag_tdo_i     = 1'b0;
    uphy_dp_rx_i   = 1'b0;
    uphy_dn_rx_i   = 1'b0;
    uphy_d_rx_i    = 1'b0;
    uphy_sense_i   = 1'b0;

    repeat (RESET_CYCLES) @(negedge io_clk_i);
    rst_n_i = 1'b1;
    count_release_edges("startup", edges);
    check_value("startup", "edges to board reset release", 2, edges);
    finish_test("startup");

    run_routing_test("pass_through", 0);
    run_routing_test("jtag_overlay", 1);
    run_routing_test("pinflip_undo", 2);
    run_routing_test("phy_select", 3);
    reset_test();

    $display("Tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+common
common/io_route_pkg.sv
jtag_overlay/jtag_overlay_mux.sv
usb_pinflip/usb_pinflip_mux.sv
logic/reset_sync.sv
logic/io_route_top.sv
sim/tb_io_route.sv
